// ==== common/frame_pkg.sv ====
package frame_pkg;

	// Frame geometry
	localparam int beat_bytes = 5;
	localparam int beat_bits = beat_bytes * 8;
	localparam int header_bytes = 14;
	localparam int payload_bytes = 80;
	localparam int frame_bytes = header_bytes + payload_bytes;
	localparam int frame_beats = (frame_bytes + beat_bytes - 1) / beat_bytes;

	// Final beat carries 4 of 5 lanes
	localparam logic [beat_bytes-1:0] last_keep = 5'b01111;

	localparam logic [31:0] prbs_seed = 32'hffff_ffff;

	// Lane 0 is bits 7:0 and goes out first
	typedef logic [beat_bits-1:0] beat_t;
	typedef logic [beat_bytes-1:0] keep_t;

	typedef logic [47:0] mac_t;
	typedef logic [15:0] ether_type_t;
	typedef logic [31:0] prbs_word_t;

	typedef enum logic [1:0] {
		gen_idle,
		gen_send,
		gen_done
	} gen_state_t;

endpackage

// ==== common/payload_if.sv ====
`timescale 1ns/1ps

interface payload_if;

	logic valid;
	frame_pkg::beat_t data;
	frame_pkg::keep_t keep;
	logic last;

	// Driven by header capture and read by the payload checker
	modport source (
		output valid,
		output data,
		output keep,
		output last
	);

	modport sink (
		input valid,
		input data,
		input keep,
		input last
	);

endinterface

// ==== design/prbs_word_source.sv ====
`timescale 1ns/1ps

module prbs_word_source (
	input logic clock,
	input logic reset,
	input logic restart,
	input logic advance,
	output frame_pkg::prbs_word_t word,
	output frame_pkg::prbs_word_t next_word
);

	// Feedback x^32 + x^22 + x^2 + x + 1 into bit 31 of a right shift
	function automatic frame_pkg::prbs_word_t prbs_step(input frame_pkg::prbs_word_t s);
		return {s[0] ^ s[10] ^ s[30] ^ s[31], s[31:1]};
	endfunction

	localparam frame_pkg::prbs_word_t first_word = prbs_step(frame_pkg::prbs_seed);
	localparam frame_pkg::prbs_word_t second_word = prbs_step(first_word);

	always_ff @(posedge clock) begin
		if (reset || restart) begin
			word <= first_word;
			next_word <= second_word;
		end else if (advance) begin
			word <= next_word;
			next_word <= prbs_step(next_word);
		end
	end

	a_no_restart_and_advance: assert property (
		@(posedge clock) disable iff (reset) !(restart && advance)
	);

endmodule

// ==== frame_gen/frame_packer.sv ====
`timescale 1ns/1ps

module frame_packer (
	input logic clock,
	input logic reset,
	input logic start,
	input frame_pkg::mac_t dest_mac,
	input frame_pkg::mac_t src_mac,
	input frame_pkg::ether_type_t ether_type,
	output logic tvalid,
	input logic tready,
	output frame_pkg::beat_t tdata,
	output frame_pkg::keep_t tkeep,
	output logic tlast,
	output logic busy
);

	frame_pkg::gen_state_t state;
	logic [4:0] beat_cnt;
	logic [111:0] hdr_q;
	logic [111:0] hdr_src;

	// PRBS byte buffer holding the next payload byte in byte 0
	logic [127:0] pbuf;
	logic [4:0] fill;
	logic [159:0] window;
	logic [2:0] n_pay;
	logic [2:0] n_used;
	logic app;

	logic load;
	logic beat_last;
	logic prbs_restart;
	logic prbs_advance;
	frame_pkg::prbs_word_t prbs_word;

	frame_pkg::beat_t beat_data;
	frame_pkg::keep_t beat_keep;

	prbs_word_source prbs (
		.clock(clock),
		.reset(reset),
		.restart(prbs_restart),
		.advance(prbs_advance),
		.word(prbs_word),
		.next_word()
	);

	assign hdr_src = (state == frame_pkg::gen_idle) ? {dest_mac, src_mac, ether_type} : hdr_q;
	assign load = (state == frame_pkg::gen_idle) ? start : (state == frame_pkg::gen_send) && tready;
	assign beat_last = (beat_cnt == 5'(frame_pkg::frame_beats - 1));
	assign prbs_restart = load && beat_last;

	assign window = {32'b0, pbuf} | ({128'b0, prbs_word} << (8 * fill));
	assign n_used = load ? n_pay : 3'd0;
	// Take another word only while it fits after this cycle's consumption
	assign app = ({1'b0, fill} + 6'd4 <= 6'd16 + {3'b0, n_used}) && !prbs_restart;
	assign prbs_advance = app;

	always_comb begin
		int m;
		int np;
		beat_data = '0;
		beat_keep = '0;
		np = 0;
		for (int i = 0; i < frame_pkg::beat_bytes; i++) begin
			m = int'(beat_cnt) * frame_pkg::beat_bytes + i;
			if (m < frame_pkg::header_bytes) begin
				beat_data[8*i +: 8] = hdr_src[111 - 8*m -: 8];
				beat_keep[i] = 1'b1;
			end else if (m < frame_pkg::frame_bytes) begin
				beat_data[8*i +: 8] = window[8*np +: 8];
				beat_keep[i] = 1'b1;
				np++;
			end
		end
		n_pay = 3'(np);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= frame_pkg::gen_idle;
			tvalid <= 1'b0;
			busy <= 1'b0;
			beat_cnt <= '0;
			fill <= '0;
		end else begin
			if (prbs_restart)
				fill <= '0;
			else
				fill <= fill + (app ? 5'd4 : 5'd0) - {2'b0, n_used};

			case (state)
				frame_pkg::gen_idle: begin
					if (start) begin
						tvalid <= 1'b1;
						busy <= 1'b1;
						beat_cnt <= 5'd1;
						state <= frame_pkg::gen_send;
					end
				end
				frame_pkg::gen_send: begin
					if (tready) begin
						beat_cnt <= beat_cnt + 5'd1;
						if (beat_last)
							state <= frame_pkg::gen_done;
					end
				end
				frame_pkg::gen_done: begin
					// Last beat is on the bus
					if (tready) begin
						tvalid <= 1'b0;
						busy <= 1'b0;
						beat_cnt <= '0;
						state <= frame_pkg::gen_idle;
					end
				end
				default: state <= frame_pkg::gen_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset || prbs_restart)
			pbuf <= '0;
		else if (app)
			pbuf <= 128'(window >> (8 * n_used));
		else
			pbuf <= pbuf >> (8 * n_used);
		if (state == frame_pkg::gen_idle && start)
			hdr_q <= {dest_mac, src_mac, ether_type};
		if (load) begin
			tdata <= beat_data;
			tkeep <= beat_keep;
			tlast <= beat_last;
		end
	end

	a_stable_under_backpressure: assert property (
		@(posedge clock) disable iff (reset)
		tvalid && !tready |=> tvalid && $stable(tdata) && $stable(tkeep) && $stable(tlast)
	);

	a_last_keep: assert property (
		@(posedge clock) disable iff (reset) tvalid && tlast |-> tkeep == frame_pkg::last_keep
	);

endmodule

// ==== frame_check/header_capture.sv ====
`timescale 1ns/1ps

module header_capture (
	input logic clock,
	input logic reset,
	input logic rx_valid,
	input frame_pkg::beat_t rx_data,
	input frame_pkg::keep_t rx_keep,
	input logic rx_last,
	output frame_pkg::mac_t dest_mac,
	output frame_pkg::mac_t src_mac,
	output frame_pkg::ether_type_t ether_type,
	output logic header_valid,
	payload_if.source payload
);

	// Bytes of the current frame seen so far
	logic [7:0] byte_cnt;
	logic [8:0] cnt_sum;
	logic [2:0] n_kept;

	logic [111:0] hdr_work;
	logic [111:0] hdr_next;
	frame_pkg::keep_t hdr_lanes;
	logic hdr_done;

	always_comb begin
		int idx;
		int nk;
		hdr_next = hdr_work;
		hdr_lanes = '0;
		nk = 0;
		for (int i = 0; i < frame_pkg::beat_bytes; i++) begin
			idx = int'(byte_cnt) + i;
			if (rx_keep[i]) begin
				nk++;
				if (idx < frame_pkg::header_bytes) begin
					hdr_next = {hdr_next[103:0], rx_data[8*i +: 8]};
					hdr_lanes[i] = 1'b1;
				end
			end
		end
		n_kept = 3'(nk);
	end

	assign cnt_sum = {1'b0, byte_cnt} + {6'b0, n_kept};
	assign hdr_done = rx_valid && (byte_cnt < 8'(frame_pkg::header_bytes))
		&& (cnt_sum >= 9'(frame_pkg::header_bytes));

	always_ff @(posedge clock) begin
		if (reset) begin
			byte_cnt <= '0;
			header_valid <= 1'b0;
			payload.valid <= 1'b0;
			payload.last <= 1'b0;
		end else begin
			header_valid <= hdr_done;
			payload.valid <= rx_valid;
			payload.last <= rx_valid && rx_last;
			if (rx_valid) begin
				if (rx_last)
					byte_cnt <= '0;
				else if (cnt_sum[8])
					byte_cnt <= 8'hff;
				else
					byte_cnt <= cnt_sum[7:0];
			end
		end
	end

	always_ff @(posedge clock) begin
		payload.data <= rx_data;
		payload.keep <= rx_keep & ~hdr_lanes;
		if (rx_valid)
			hdr_work <= hdr_next;
		// Fields only move once a whole header is in
		if (hdr_done) begin
			dest_mac <= hdr_next[111:64];
			src_mac <= hdr_next[63:16];
			ether_type <= hdr_next[15:0];
		end
	end

endmodule

// ==== frame_check/payload_checker.sv ====
`timescale 1ns/1ps

module payload_checker (
	input logic clock,
	input logic reset,
	payload_if.sink payload,
	output logic frame_done,
	output logic frame_error,
	output logic [15:0] error_count
);

	logic [127:0] pbuf;
	logic [4:0] fill;
	logic [159:0] window;
	logic [2:0] n_used;
	logic [2:0] n_bad;
	logic app;

	logic prbs_restart;
	frame_pkg::prbs_word_t prbs_word;

	logic [7:0] pay_cnt;
	logic [8:0] pay_sum;
	logic any_bad;
	logic [16:0] err_sum;

	prbs_word_source prbs (
		.clock(clock),
		.reset(reset),
		.restart(prbs_restart),
		.advance(app),
		.word(prbs_word),
		.next_word()
	);

	assign prbs_restart = payload.valid && payload.last;
	assign window = {32'b0, pbuf} | ({128'b0, prbs_word} << (8 * fill));
	assign app = ({1'b0, fill} + 6'd4 <= 6'd16 + {3'b0, n_used}) && !prbs_restart;

	// Kept lanes are compared in order against the expected bytes
	always_comb begin
		int np;
		int nb;
		np = 0;
		nb = 0;
		if (payload.valid) begin
			for (int i = 0; i < frame_pkg::beat_bytes; i++) begin
				if (payload.keep[i]) begin
					if (payload.data[8*i +: 8] != window[8*np +: 8])
						nb++;
					np++;
				end
			end
		end
		n_used = 3'(np);
		n_bad = 3'(nb);
	end

	assign pay_sum = {1'b0, pay_cnt} + {6'b0, n_used};
	assign err_sum = {1'b0, error_count} + {14'b0, n_bad};

	always_ff @(posedge clock) begin
		if (reset) begin
			fill <= '0;
			pay_cnt <= '0;
			any_bad <= 1'b0;
			frame_done <= 1'b0;
			frame_error <= 1'b0;
			error_count <= '0;
		end else begin
			if (prbs_restart)
				fill <= '0;
			else
				fill <= fill + (app ? 5'd4 : 5'd0) - {2'b0, n_used};

			error_count <= err_sum[16] ? 16'hffff : err_sum[15:0];
			frame_done <= prbs_restart;

			if (prbs_restart) begin
				frame_error <= any_bad || (n_bad != 3'd0)
					|| (pay_sum != 9'(frame_pkg::payload_bytes));
				pay_cnt <= '0;
				any_bad <= 1'b0;
			end else if (payload.valid) begin
				pay_cnt <= pay_sum[8] ? 8'hff : pay_sum[7:0];
				any_bad <= any_bad || (n_bad != 3'd0);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset || prbs_restart)
			pbuf <= '0;
		else if (app)
			pbuf <= 128'(window >> (8 * n_used));
		else
			pbuf <= pbuf >> (8 * n_used);
	end

	a_done_single_pulse: assert property (
		@(posedge clock) disable iff (reset) frame_done |=> !frame_done
	);

endmodule

// ==== design/eth_prbs_top.sv ====
`timescale 1ns/1ps

module eth_prbs_top (
	input logic clock,
	input logic reset,
	input logic start,
	input frame_pkg::mac_t dest_mac,
	input frame_pkg::mac_t src_mac,
	input frame_pkg::ether_type_t ether_type,
	output logic tvalid,
	input logic tready,
	output frame_pkg::beat_t tdata,
	output frame_pkg::keep_t tkeep,
	output logic tlast,
	output logic busy,
	input logic rx_valid,
	input frame_pkg::beat_t rx_data,
	input frame_pkg::keep_t rx_keep,
	input logic rx_last,
	output frame_pkg::mac_t rx_dest_mac,
	output frame_pkg::mac_t rx_src_mac,
	output frame_pkg::ether_type_t rx_ether_type,
	output logic header_valid,
	output logic frame_done,
	output logic frame_error,
	output logic [15:0] error_count
);

	payload_if payload_bus ();

	// Transmit side
	frame_packer packer (
		.clock(clock),
		.reset(reset),
		.start(start),
		.dest_mac(dest_mac),
		.src_mac(src_mac),
		.ether_type(ether_type),
		.tvalid(tvalid),
		.tready(tready),
		.tdata(tdata),
		.tkeep(tkeep),
		.tlast(tlast),
		.busy(busy)
	);

	// Receive side
	header_capture capture (
		.clock(clock),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rx_keep(rx_keep),
		.rx_last(rx_last),
		.dest_mac(rx_dest_mac),
		.src_mac(rx_src_mac),
		.ether_type(rx_ether_type),
		.header_valid(header_valid),
		.payload(payload_bus)
	);

	payload_checker payload_check (
		.clock(clock),
		.reset(reset),
		.payload(payload_bus),
		.frame_done(frame_done),
		.frame_error(frame_error),
		.error_count(error_count)
	);

endmodule

// ==== sim/tb_eth_prbs.sv ====
`timescale 1ns/1ps

module tb_eth_prbs;

	localparam int frame_limit = 200;
	localparam int frame_cycles = 60;
	localparam int watchdog_cycles = 40 * frame_cycles;

	logic clock;
	logic reset;
	logic start;
	frame_pkg::mac_t dest_mac;
	frame_pkg::mac_t src_mac;
	frame_pkg::ether_type_t ether_type;
	logic tvalid;
	logic tready = 1'b0;
	frame_pkg::beat_t tdata;
	frame_pkg::keep_t tkeep;
	logic tlast;
	logic busy;
	logic rx_valid = 1'b0;
	frame_pkg::beat_t rx_data = '0;
	frame_pkg::keep_t rx_keep = '0;
	logic rx_last = 1'b0;
	frame_pkg::mac_t rx_dest_mac;
	frame_pkg::mac_t rx_src_mac;
	frame_pkg::ether_type_t rx_ether_type;
	logic header_valid;
	logic frame_done;
	logic frame_error;
	logic [15:0] error_count;

	int mismatch_count = 0;
	int failure_count = 0;
	integer seed = 32'h440b;
	integer rnd;

	// Loopback controls, only changed while the generator is idle
	logic ready_random = 1'b0;
	logic corrupt_on = 1'b0;
	int corrupt_pos = 0;
	logic [7:0] corrupt_mask = 8'h00;
	logic truncate_on = 1'b0;

	logic pend_valid = 1'b0;
	frame_pkg::beat_t pend_data = '0;
	frame_pkg::keep_t pend_keep = '0;
	logic pend_last = 1'b0;
	logic hold_prev = 1'b0;
	frame_pkg::beat_t hold_data;
	frame_pkg::keep_t hold_keep;
	logic hold_last;
	int beat_idx = 0;
	int cycle_count = 0;
	int done_total = 0;
	int header_total = 0;
	int hold_total = 0;
	logic last_frame_error = 1'b0;

	// Beats seen on the generator output
	frame_pkg::beat_t got_data [$];
	frame_pkg::keep_t got_keep [$];
	logic got_last [$];
	int got_cycle [$];

	logic [7:0] exp_bytes [0:frame_pkg::frame_bytes-1];

	eth_prbs_top uut (.*);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
		$display("tests failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		mismatch_count++;
		$display("MISMATCH %s: got %h expected %h", name, got, exp);
	endtask

	function automatic frame_pkg::prbs_word_t lfsr_step(input frame_pkg::prbs_word_t s);
		return {s[0] ^ s[10] ^ s[30] ^ s[31], s[31:1]};
	endfunction

	// Expected wire bytes of one frame
	function automatic void build_model(input frame_pkg::mac_t d, input frame_pkg::mac_t s,
			input frame_pkg::ether_type_t e);
		frame_pkg::prbs_word_t w;
		for (int m = 0; m < 6; m++) begin
			exp_bytes[m] = d[47 - 8*m -: 8];
			exp_bytes[6 + m] = s[47 - 8*m -: 8];
		end
		exp_bytes[12] = e[15:8];
		exp_bytes[13] = e[7:0];
		w = frame_pkg::prbs_seed;
		for (int n = 0; n < frame_pkg::payload_bytes; n++) begin
			if (n % 4 == 0)
				w = lfsr_step(w);
			exp_bytes[frame_pkg::header_bytes + n] = w[8*(n%4) +: 8];
		end
	endfunction

	// Loopback, monitors and tready policy in one process
	always @(negedge clock) begin
		rx_valid = pend_valid;
		rx_data = pend_data;
		rx_keep = pend_keep;
		rx_last = pend_last;
		cycle_count++;
		if (frame_done) begin
			done_total++;
			last_frame_error = frame_error;
		end
		if (header_valid)
			header_total++;
		if (hold_prev && tvalid) begin
			if (tdata !== hold_data)
				report_mismatch("tdata held", 64'(tdata), 64'(hold_data));
			if (tkeep !== hold_keep)
				report_mismatch("tkeep held", 64'(tkeep), 64'(hold_keep));
			if (tlast !== hold_last)
				report_mismatch("tlast held", 64'(tlast), 64'(hold_last));
		end else if (hold_prev) begin
			failure_count++;
			$display("tvalid dropped while a beat waited for tready");
		end
		if (ready_random) begin
			rnd = $random(seed);
			tready = rnd[0];
		end else begin
			tready = 1'b1;
		end
		hold_prev = tvalid && !tready;
		if (hold_prev)
			hold_total++;
		hold_data = tdata;
		hold_keep = tkeep;
		hold_last = tlast;
		pend_valid = 1'b0;
		pend_last = 1'b0;
		if (tvalid && tready) begin
			got_data.push_back(tdata);
			got_keep.push_back(tkeep);
			got_last.push_back(tlast);
			got_cycle.push_back(cycle_count);
			pend_valid = 1'b1;
			pend_data = tdata;
			pend_keep = tkeep;
			pend_last = tlast;
			if (corrupt_on && beat_idx == corrupt_pos / frame_pkg::beat_bytes)
				pend_data[8*(corrupt_pos % frame_pkg::beat_bytes) +: 8] =
					pend_data[8*(corrupt_pos % frame_pkg::beat_bytes) +: 8] ^ corrupt_mask;
			// Cut the frame after beat 10 and drop the rest
			if (truncate_on && beat_idx == 10)
				pend_last = 1'b1;
			if (truncate_on && beat_idx > 10)
				pend_valid = 1'b0;
			beat_idx = tlast ? 0 : beat_idx + 1;
		end
	end

	task automatic send_start(input frame_pkg::mac_t d, input frame_pkg::mac_t s,
			input frame_pkg::ether_type_t e);
		@(negedge clock);
		dest_mac = d;
		src_mac = s;
		ether_type = e;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < frame_limit) begin
			@(negedge clock);
			n++;
		end
		if (busy) begin
			failure_count++;
			$display("generator still busy after %0d cycles", frame_limit);
		end
	endtask

	task automatic wait_done(input int target);
		int n;
		n = 0;
		while (done_total < target && n < frame_limit) begin
			@(negedge clock);
			n++;
		end
		if (done_total < target) begin
			failure_count++;
			$display("frame_done did not arrive within %0d cycles", frame_limit);
		end
	endtask

	task automatic clear_capture();
		got_data.delete();
		got_keep.delete();
		got_last.delete();
		got_cycle.delete();
	endtask

	task automatic run_frame(input frame_pkg::mac_t d, input frame_pkg::mac_t s,
			input frame_pkg::ether_type_t e);
		int base;
		base = done_total;
		clear_capture();
		send_start(d, s, e);
		wait_idle();
		wait_done(base + 1);
	endtask

	task automatic check_beats(input frame_pkg::mac_t d, input frame_pkg::mac_t s,
			input frame_pkg::ether_type_t e, input logic consecutive);
		frame_pkg::beat_t exp_data;
		frame_pkg::keep_t exp_keep;
		logic exp_last;
		int first_cycle;
		int m;
		build_model(d, s, e);
		if (got_data.size() < frame_pkg::frame_beats) begin
			failure_count++;
			$display("only %0d beats transferred, %0d expected", got_data.size(),
				frame_pkg::frame_beats);
			return;
		end
		first_cycle = got_cycle[0];
		for (int b = 0; b < frame_pkg::frame_beats; b++) begin
			exp_data = '0;
			exp_keep = '0;
			exp_last = (b == frame_pkg::frame_beats - 1);
			for (int i = 0; i < frame_pkg::beat_bytes; i++) begin
				m = b * frame_pkg::beat_bytes + i;
				if (m < frame_pkg::frame_bytes) begin
					exp_data[8*i +: 8] = exp_bytes[m];
					exp_keep[i] = 1'b1;
				end
			end
			if (got_data[0] !== exp_data)
				report_mismatch($sformatf("tdata beat %0d", b), 64'(got_data[0]), 64'(exp_data));
			if (got_keep[0] !== exp_keep)
				report_mismatch($sformatf("tkeep beat %0d", b), 64'(got_keep[0]), 64'(exp_keep));
			if (got_last[0] !== exp_last)
				report_mismatch($sformatf("tlast beat %0d", b), 64'(got_last[0]), 64'(exp_last));
			if (consecutive && got_cycle[0] != first_cycle + b) begin
				failure_count++;
				$display("beat %0d did not follow the previous beat on the next cycle", b);
			end
			got_data.delete(0);
			got_keep.delete(0);
			got_last.delete(0);
			got_cycle.delete(0);
		end
	endtask

	task automatic check_header(input frame_pkg::mac_t d, input frame_pkg::mac_t s,
			input frame_pkg::ether_type_t e);
		if (rx_dest_mac !== d)
			report_mismatch("rx_dest_mac", 64'(rx_dest_mac), 64'(d));
		if (rx_src_mac !== s)
			report_mismatch("rx_src_mac", 64'(rx_src_mac), 64'(s));
		if (rx_ether_type !== e)
			report_mismatch("rx_ether_type", 64'(rx_ether_type), 64'(e));
	endtask

	task automatic test_reset_state();
		if (tvalid !== 1'b0)
			report_mismatch("tvalid", 64'(tvalid), 64'h0);
		if (busy !== 1'b0)
			report_mismatch("busy", 64'(busy), 64'h0);
		if (header_valid !== 1'b0)
			report_mismatch("header_valid", 64'(header_valid), 64'h0);
		if (frame_done !== 1'b0)
			report_mismatch("frame_done", 64'(frame_done), 64'h0);
		if (frame_error !== 1'b0)
			report_mismatch("frame_error", 64'(frame_error), 64'h0);
		if (error_count !== 16'h0)
			report_mismatch("error_count", 64'(error_count), 64'h0);
	endtask

	task automatic test_single_frame();
		int hbase;
		hbase = header_total;
		run_frame(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5);
		check_beats(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5, 1'b1);
		check_header(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5);
		if (header_total != hbase + 1) begin
			failure_count++;
			$display("header_valid pulsed %0d times for one frame", header_total - hbase);
		end
		if (last_frame_error !== 1'b0)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h0);
	endtask

	task automatic test_backpressure();
		int hold_base;
		hold_base = hold_total;
		ready_random = 1'b1;
		run_frame(48'h001122334455, 48'h66778899aabb, 16'h0806);
		ready_random = 1'b0;
		check_beats(48'h001122334455, 48'h66778899aabb, 16'h0806, 1'b0);
		if (hold_total == hold_base) begin
			failure_count++;
			$display("tready never stalled a valid beat");
		end
		if (last_frame_error !== 1'b0)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h0);
	endtask

	task automatic test_corruption();
		logic [15:0] err_before;
		frame_pkg::mac_t bad_dest;
		err_before = error_count;
		corrupt_on = 1'b1;
		corrupt_pos = 50;
		corrupt_mask = 8'h5a;
		run_frame(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5);
		if (last_frame_error !== 1'b1)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h1);
		if (error_count !== err_before + 16'd1)
			report_mismatch("error_count", 64'(error_count), 64'(err_before + 16'd1));
		// Destination byte 3 flipped in flight
		err_before = error_count;
		corrupt_pos = 3;
		corrupt_mask = 8'h01;
		bad_dest = 48'h02005e102030;
		bad_dest[47 - 8*3 -: 8] = bad_dest[47 - 8*3 -: 8] ^ 8'h01;
		run_frame(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5);
		corrupt_on = 1'b0;
		check_header(bad_dest, 48'h0a1b2c3d4e5f, 16'h88b5);
		if (last_frame_error !== 1'b0)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h0);
		if (error_count !== err_before)
			report_mismatch("error_count", 64'(error_count), 64'(err_before));
	endtask

	task automatic test_back_to_back();
		int base;
		base = done_total;
		clear_capture();
		send_start(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5);
		repeat (5) @(negedge clock);
		// Start pulse in the middle of a frame
		send_start(48'hffffffffffff, 48'h001122334455, 16'h0800);
		wait_idle();
		send_start(48'hffffffffffff, 48'h001122334455, 16'h0800);
		wait_idle();
		wait_done(base + 2);
		check_beats(48'h02005e102030, 48'h0a1b2c3d4e5f, 16'h88b5, 1'b1);
		check_beats(48'hffffffffffff, 48'h001122334455, 16'h0800, 1'b1);
		check_header(48'hffffffffffff, 48'h001122334455, 16'h0800);
		if (last_frame_error !== 1'b0)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h0);
		repeat (40) @(negedge clock);
		if (got_data.size() != 0 || busy || done_total != base + 2) begin
			failure_count++;
			$display("start during busy produced an extra frame");
		end
	endtask

	task automatic test_truncated();
		logic [15:0] err_before;
		err_before = error_count;
		truncate_on = 1'b1;
		run_frame(48'h0a0b0c0d0e0f, 48'h102030405060, 16'h86dd);
		truncate_on = 1'b0;
		if (last_frame_error !== 1'b1)
			report_mismatch("frame_error", 64'(last_frame_error), 64'h1);
		if (error_count !== err_before)
			report_mismatch("error_count", 64'(error_count), 64'(err_before));
	endtask

	initial begin
		reset = 1'b1;
		start = 1'b0;
		dest_mac = '0;
		src_mac = '0;
		ether_type = '0;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		test_reset_state();
		test_single_frame();
		test_backpressure();
		test_corruption();
		test_back_to_back();
		test_truncated();
		$display("mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// ==== project.f ====
common/frame_pkg.sv
common/payload_if.sv
design/prbs_word_source.sv
frame_gen/frame_packer.sv
frame_check/header_capture.sv
frame_check/payload_checker.sv
design/eth_prbs_top.sv
sim/tb_eth_prbs.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP := tb_eth_prbs
RTL_TOP := eth_prbs_top
FILE_LIST := project.f
OBJ_DIR := obj_dir
LOG := sim.log
FLAGS := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "all tests passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
